// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := tb_div
DUT_TOP    := div_top
FILELIST   := sources.f
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert $(COMMON)
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result width
`define DIV_XLEN 64

// Bit index and iteration count width
// Must hold the index of the top operand bit
`define DIV_CNT_W 6

`endif

// File: div_ctrl.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module div_ctrl (
  input  logic                  div_clk,
  input  logic                  cpurst_b,
  input  logic                  start,
  input  div_pkg::div_op_e      op,
  input  logic [`DIV_XLEN-1:0]  src0,
  input  logic [`DIV_XLEN-1:0]  src1,
  input  logic                  iter_cmplt,
  input  logic [`DIV_XLEN-1:0]  divisor_update_data,
  input  logic [`DIV_XLEN-1:0]  quotient_reg_updt,
  input  logic [`DIV_XLEN-1:0]  remainder_reg_updt,
  output logic                  busy,
  output logic [`DIV_XLEN-1:0]  ff1_src,
  output logic                  prepare_src0,
  output logic                  prepare_src1,
  output logic                  align,
  output logic                  iterating,
  output logic [`DIV_XLEN-1:0]  divisor_reg,
  output logic [`DIV_XLEN-1:0]  quotient_reg,
  output logic [`DIV_XLEN-1:0]  remainder_reg,
  output logic                  fix_req,
  output div_pkg::div_op_e      fix_op,
  output logic [`DIV_XLEN-1:0]  fix_src0,
  output logic [`DIV_XLEN-1:0]  fix_src1,
  output logic [`DIV_XLEN-1:0]  fix_quotient,
  output logic [`DIV_XLEN-1:0]  fix_remainder,
  output logic                  neg_src0,
  output logic                  neg_src1
);

  import div_pkg::*;

  div_state_e           state;
  div_state_e           state_nxt;
  div_op_e              op_reg;
  logic [`DIV_XLEN-1:0] src0_reg;
  logic [`DIV_XLEN-1:0] src1_reg;
  logic [`DIV_XLEN-1:0] abs_src0;
  logic [`DIV_XLEN-1:0] abs_src1;
  logic                 is_signed;
  logic                 start_accept;

  //------------------------------------------------------------
  // State machine
  //------------------------------------------------------------
  // Start only counts in IDLE
  assign start_accept = start && (state == IDLE);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:    state_nxt = start ? PREP0 : IDLE;
      PREP0:   state_nxt = PREP1;
      PREP1:   state_nxt = ALIGN;
      ALIGN:   state_nxt = ITER;
      ITER:    state_nxt = iter_cmplt ? FIX : ITER;
      FIX:     state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Busy drops as the fixup stage raises done
  assign busy         = (state != IDLE);
  assign prepare_src0 = (state == PREP0);
  assign prepare_src1 = (state == PREP1);
  assign align        = (state == ALIGN);
  assign iterating    = (state == ITER);
  assign fix_req      = (state == FIX);

  //------------------------------------------------------------
  // Operand latch and magnitude
  //------------------------------------------------------------
  always_ff @(posedge div_clk)
  begin
    if (start_accept)
    begin
      op_reg   <= op;
      src0_reg <= src0;
      src1_reg <= src1;
    end
  end

  // DIV and REM take signed operands
  assign is_signed = !op_reg[0];
  assign neg_src0  = is_signed && src0_reg[`DIV_XLEN-1];
  assign neg_src1  = is_signed && src1_reg[`DIV_XLEN-1];

  // Two's complement magnitude, most negative maps onto itself
  assign abs_src0 = neg_src0 ? -src0_reg : src0_reg;
  assign abs_src1 = neg_src1 ? -src1_reg : src1_reg;

  // Encoder sees the dividend first, then the divisor
  assign ff1_src = (state == PREP1) ? abs_src1 : abs_src0;

  //------------------------------------------------------------
  // Datapath registers
  //------------------------------------------------------------
  always_ff @(posedge div_clk)
  begin
    case (state)
      PREP0:
      begin
        remainder_reg <= abs_src0;
        quotient_reg  <= '0;
      end
      PREP1:
        divisor_reg <= abs_src1;
      ALIGN:
        divisor_reg <= divisor_update_data;
      ITER:
      begin
        divisor_reg   <= divisor_update_data;
        quotient_reg  <= quotient_reg_updt;
        remainder_reg <= remainder_reg_updt;
      end
      default:
      begin
        divisor_reg <= divisor_reg;
      end
    endcase
  end

  // Hand-off to the fixup stage
  assign fix_op        = op_reg;
  assign fix_src0      = src0_reg;
  assign fix_src1      = src1_reg;
  assign fix_quotient  = quotient_reg;
  assign fix_remainder = remainder_reg;

  // Start during a division neither restarts nor disturbs the operands
  a_start_busy_ignored: assert property (@(posedge div_clk) disable iff (!cpurst_b)
    busy && start |=> (state != PREP0) && $stable(src0_reg) && $stable(src1_reg));

  // At most 33 digit-pair steps
  a_iter_bound: assert property (@(posedge div_clk) disable iff (!cpurst_b)
    $rose(state == ITER) |-> ##[1:33] (state != ITER));

endmodule

`default_nettype wire

// File: div_ff1.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module div_ff1 (
  input  logic [`DIV_XLEN-1:0]  ff1_src,
  output logic [`DIV_CNT_W-1:0] ff1_res
);

  //------------------------------------------------------------
  // Leading one search
  //------------------------------------------------------------
  // Byte level first, then bit level inside the chosen byte
  logic [7:0] byte_nz;
  logic [2:0] byte_idx;
  logic [7:0] byte_sel;
  logic [2:0] bit_idx;

  // One flag per byte of the source
  always_comb
  begin
    for (int b = 0; b < 8; b++)
    begin
      byte_nz[b] = |ff1_src[b*8 +: 8];
    end
  end

  // Highest non-zero byte wins, byte 0 for zero input
  always_comb
  begin
    byte_idx = 3'd0;
    for (int b = 0; b < 8; b++)
    begin
      if (byte_nz[b])
        byte_idx = 3'(b);
    end
  end

  assign byte_sel = ff1_src[byte_idx*8 +: 8];

  // Highest set bit of that byte
  always_comb
  begin
    bit_idx = 3'd0;
    for (int i = 0; i < 8; i++)
    begin
      if (byte_sel[i])
        bit_idx = 3'(i);
    end
  end

  // Zero input falls out as index 0
  assign ff1_res = {byte_idx, bit_idx};

endmodule

`default_nettype wire

// File: div_pkg.sv
`default_nettype none

package div_pkg;

  // Opcode encoding
  // Bit 0 set means unsigned, bit 1 set means remainder
  typedef enum logic [1:0] {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } div_op_e;

  // Controller states
  // PREP0 and PREP1 share the leading-one encoder in turn
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    PREP0 = 3'd1,
    PREP1 = 3'd2,
    ALIGN = 3'd3,
    ITER  = 3'd4,
    FIX   = 3'd5
  } div_state_e;

endpackage

`default_nettype wire

// File: div_result_fix.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module div_result_fix (
  input  logic                 div_clk,
  input  logic                 cpurst_b,
  input  logic                 fix_req,
  input  div_pkg::div_op_e     fix_op,
  input  logic [`DIV_XLEN-1:0] fix_src0,
  input  logic [`DIV_XLEN-1:0] fix_src1,
  input  logic [`DIV_XLEN-1:0] fix_quotient,
  input  logic [`DIV_XLEN-1:0] fix_remainder,
  input  logic                 neg_src0,
  input  logic                 neg_src1,
  output logic                 done,
  output logic [`DIV_XLEN-1:0] result
);

  import div_pkg::*;

  logic                 is_rem;
  logic                 div_by_zero;
  logic                 signed_ovf;
  logic                 neg_quot;
  logic                 neg_rem;
  logic [`DIV_XLEN-1:0] quot_fixed;
  logic [`DIV_XLEN-1:0] rem_fixed;
  logic [`DIV_XLEN-1:0] result_nxt;

  //------------------------------------------------------------
  // Special cases
  //------------------------------------------------------------
  assign is_rem      = (fix_op == REM) || (fix_op == REMU);
  assign div_by_zero = (fix_src1 == '0);

  // Most negative over minus one, signed opcodes only
  assign signed_ovf = ((fix_op == DIV) || (fix_op == REM))
                   && (fix_src0 == {1'b1, {(`DIV_XLEN-1){1'b0}}})
                   && (fix_src1 == {`DIV_XLEN{1'b1}});

  // Quotient sign from operand signs, remainder follows dividend
  assign neg_quot = (fix_op == DIV) && (neg_src0 ^ neg_src1);
  assign neg_rem  = (fix_op == REM) && neg_src0;

  assign quot_fixed = neg_quot ? -fix_quotient  : fix_quotient;
  assign rem_fixed  = neg_rem  ? -fix_remainder : fix_remainder;

  always_comb
  begin
    if (div_by_zero)
      result_nxt = is_rem ? fix_src0 : {`DIV_XLEN{1'b1}};
    else if (signed_ovf)
      result_nxt = is_rem ? '0 : fix_src0;
    else
      result_nxt = is_rem ? rem_fixed : quot_fixed;
  end

  //------------------------------------------------------------
  // Result register and done pulse
  //------------------------------------------------------------
  // Result holds until the next fix request
  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      done   <= 1'b0;
      result <= '0;
    end
    else
    begin
      done <= fix_req;
      if (fix_req)
        result <= result_nxt;
    end
  end

endmodule

`default_nettype wire

// File: div_shift2_kernel.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module div_shift2_kernel (
  input  logic                  div_clk,
  input  logic                  cpurst_b,
  input  logic                  align,
  input  logic                  iterating,
  input  logic                  prepare_src0,
  input  logic                  prepare_src1,
  input  logic [`DIV_CNT_W-1:0] ff1_res,
  input  logic [`DIV_XLEN-1:0]  divisor_reg,
  input  logic [`DIV_XLEN-1:0]  quotient_reg,
  input  logic [`DIV_XLEN-1:0]  remainder_reg,
  output logic [`DIV_XLEN-1:0]  divisor_update_data,
  output logic                  iter_cmplt,
  output logic [`DIV_XLEN-1:0]  quotient_reg_updt,
  output logic [`DIV_XLEN-1:0]  remainder_reg_updt
);

  logic [`DIV_CNT_W-1:0] iter_count;
  logic [`DIV_CNT_W-1:0] src1_count;
  logic [`DIV_CNT_W-1:0] iter_sub;
  logic [`DIV_CNT_W-1:0] iter_count_updt;
  logic [`DIV_XLEN+1:0]  divisor_x1;
  logic [`DIV_XLEN+1:0]  divisor_x2;
  logic [`DIV_XLEN+1:0]  divisor_x3;
  logic [`DIV_XLEN+1:0]  diff_x1;
  logic [`DIV_XLEN+1:0]  diff_x2;
  logic [`DIV_XLEN+1:0]  diff_x3;
  logic                  borrow_x1;
  logic                  borrow_x2;
  logic                  borrow_x3;
  logic [1:0]            shift_in;

  //------------------------------------------------------------
  // Iteration counter
  //------------------------------------------------------------
  // Divisor leading-one index in ALIGN, two bits per ITER cycle
  assign iter_sub = align     ? src1_count :
                    iterating ? `DIV_CNT_W'(2) :
                                '0;

  // Saturate at zero when the divisor is wider than the dividend
  assign iter_count_updt = (iter_count < iter_sub) ? '0 : iter_count - iter_sub;

  // Dividend leading-one index loaded in PREP0
  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      iter_count <= '0;
    else if (prepare_src0)
      iter_count <= ff1_res;
    else if (align || iterating)
      iter_count <= iter_count_updt;
  end

  // Divisor leading-one index loaded in PREP1
  always_ff @(posedge div_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      src1_count <= '0;
    else if (prepare_src1)
      src1_count <= ff1_res;
  end

  // Last step once fewer than two bit positions remain
  assign iter_cmplt = iterating && (iter_count[`DIV_CNT_W-1:1] == '0);

  // Align to an even shift so each step consumes a bit pair
  assign divisor_update_data = align ? divisor_reg << {iter_count_updt[`DIV_CNT_W-1:1], 1'b0}
                                     : divisor_reg >> 2;

  //------------------------------------------------------------
  // Radix-4 restoring step
  //------------------------------------------------------------
  // One, two and three times the divisor, two guard bits wide
  assign divisor_x1 = {2'b00, divisor_reg};
  assign divisor_x2 = {1'b0, divisor_reg, 1'b0};
  assign divisor_x3 = divisor_x1 + divisor_x2;

  // Borrow out means remainder below that multiple
  assign {borrow_x1, diff_x1} = {3'b000, remainder_reg} - {1'b0, divisor_x1};
  assign {borrow_x2, diff_x2} = {3'b000, remainder_reg} - {1'b0, divisor_x2};
  assign {borrow_x3, diff_x3} = {3'b000, remainder_reg} - {1'b0, divisor_x3};

  // Largest multiple that fits picks the quotient digit
  always_comb
  begin
    if (borrow_x1)
    begin
      shift_in           = 2'b00;
      remainder_reg_updt = remainder_reg;
    end
    else if (borrow_x2)
    begin
      shift_in           = 2'b01;
      remainder_reg_updt = diff_x1[`DIV_XLEN-1:0];
    end
    else if (borrow_x3)
    begin
      shift_in           = 2'b10;
      remainder_reg_updt = diff_x2[`DIV_XLEN-1:0];
    end
    else
    begin
      shift_in           = 2'b11;
      remainder_reg_updt = diff_x3[`DIV_XLEN-1:0];
    end
  end

  // New digit enters at the bottom
  assign quotient_reg_updt = {quotient_reg[`DIV_XLEN-3:0], shift_in};

  // Controller never aligns and iterates in the same cycle
  a_align_iter_excl: assert property (@(posedge div_clk) disable iff (!cpurst_b)
    !(align && iterating));

endmodule

`default_nettype wire

// File: div_top.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module div_top (
  input  logic                 div_clk,
  input  logic                 cpurst_b,
  input  logic                 start,
  input  div_pkg::div_op_e     op,
  input  logic [`DIV_XLEN-1:0] src0,
  input  logic [`DIV_XLEN-1:0] src1,
  output logic                 busy,
  output logic                 done,
  output logic [`DIV_XLEN-1:0] result
);

  import div_pkg::*;

  // Controller to encoder and kernel
  logic [`DIV_XLEN-1:0]  ff1_src;
  logic [`DIV_CNT_W-1:0] ff1_res;
  logic                  prepare_src0;
  logic                  prepare_src1;
  logic                  align;
  logic                  iterating;
  logic [`DIV_XLEN-1:0]  divisor_reg;
  logic [`DIV_XLEN-1:0]  quotient_reg;
  logic [`DIV_XLEN-1:0]  remainder_reg;

  // Kernel back to controller
  logic                  iter_cmplt;
  logic [`DIV_XLEN-1:0]  divisor_update_data;
  logic [`DIV_XLEN-1:0]  quotient_reg_updt;
  logic [`DIV_XLEN-1:0]  remainder_reg_updt;

  // Controller to fixup
  logic                  fix_req;
  div_op_e               fix_op;
  logic [`DIV_XLEN-1:0]  fix_src0;
  logic [`DIV_XLEN-1:0]  fix_src1;
  logic [`DIV_XLEN-1:0]  fix_quotient;
  logic [`DIV_XLEN-1:0]  fix_remainder;
  logic                  neg_src0;
  logic                  neg_src1;

  div_ctrl u_ctrl (
    .div_clk             (div_clk),
    .cpurst_b            (cpurst_b),
    .start               (start),
    .op                  (op),
    .src0                (src0),
    .src1                (src1),
    .iter_cmplt          (iter_cmplt),
    .divisor_update_data (divisor_update_data),
    .quotient_reg_updt   (quotient_reg_updt),
    .remainder_reg_updt  (remainder_reg_updt),
    .busy                (busy),
    .ff1_src             (ff1_src),
    .prepare_src0        (prepare_src0),
    .prepare_src1        (prepare_src1),
    .align               (align),
    .iterating           (iterating),
    .divisor_reg         (divisor_reg),
    .quotient_reg        (quotient_reg),
    .remainder_reg       (remainder_reg),
    .fix_req             (fix_req),
    .fix_op              (fix_op),
    .fix_src0            (fix_src0),
    .fix_src1            (fix_src1),
    .fix_quotient        (fix_quotient),
    .fix_remainder       (fix_remainder),
    .neg_src0            (neg_src0),
    .neg_src1            (neg_src1)
  );

  // One encoder serves both operands in turn
  div_ff1 u_ff1 (
    .ff1_src (ff1_src),
    .ff1_res (ff1_res)
  );

  div_shift2_kernel u_kernel (
    .div_clk             (div_clk),
    .cpurst_b            (cpurst_b),
    .align               (align),
    .iterating           (iterating),
    .prepare_src0        (prepare_src0),
    .prepare_src1        (prepare_src1),
    .ff1_res             (ff1_res),
    .divisor_reg         (divisor_reg),
    .quotient_reg        (quotient_reg),
    .remainder_reg       (remainder_reg),
    .divisor_update_data (divisor_update_data),
    .iter_cmplt          (iter_cmplt),
    .quotient_reg_updt   (quotient_reg_updt),
    .remainder_reg_updt  (remainder_reg_updt)
  );

  div_result_fix u_fix (
    .div_clk       (div_clk),
    .cpurst_b      (cpurst_b),
    .fix_req       (fix_req),
    .fix_op        (fix_op),
    .fix_src0      (fix_src0),
    .fix_src1      (fix_src1),
    .fix_quotient  (fix_quotient),
    .fix_remainder (fix_remainder),
    .neg_src0      (neg_src0),
    .neg_src1      (neg_src1),
    .done          (done),
    .result        (result)
  );

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
div_pkg.sv
div_ff1.sv
div_shift2_kernel.sv
div_ctrl.sv
div_result_fix.sv
div_top.sv
tb_div_check.sv
tb_div.sv

// File: tb_div.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module tb_div;

  import div_pkg::*;

  localparam int N_DIRECTED  = 27;
  localparam int N_RANDOM    = 40;
  localparam int N_ROWS      = N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = N_ROWS * 45 + 100;
  localparam int DONE_WAIT   = 50;

  localparam logic [`DIV_XLEN-1:0] ALL_ONES = {`DIV_XLEN{1'b1}};
  localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};
  localparam logic [`DIV_XLEN-1:0] NEG2     = 64'hffff_ffff_ffff_fffe;
  localparam logic [`DIV_XLEN-1:0] NEG3     = 64'hffff_ffff_ffff_fffd;
  localparam logic [`DIV_XLEN-1:0] NEG7     = 64'hffff_ffff_ffff_fff9;

  logic                 div_clk;
  logic                 cpurst_b;
  logic                 start;
  div_op_e              op;
  logic [`DIV_XLEN-1:0] src0;
  logic [`DIV_XLEN-1:0] src1;
  logic                 busy;
  logic                 done;
  logic [`DIV_XLEN-1:0] result;
  logic [`DIV_XLEN-1:0] exp_result;

  int                   chk_errors;
  int                   done_seen;
  int                   tb_errors;
  int                   cycle_cnt;
  logic [31:0]          lfsr_state;

  // Stimulus table, one division per row
  div_op_e              tbl_op  [N_ROWS];
  logic [`DIV_XLEN-1:0] tbl_a   [N_ROWS];
  logic [`DIV_XLEN-1:0] tbl_b   [N_ROWS];
  logic [`DIV_XLEN-1:0] tbl_exp [N_ROWS];
  int                   n_rows;

  div_top i_dut (
    .div_clk  (div_clk),
    .cpurst_b (cpurst_b),
    .start    (start),
    .op       (op),
    .src0     (src0),
    .src1     (src1),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  tb_div_check u_check (
    .div_clk    (div_clk),
    .cpurst_b   (cpurst_b),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .exp_result (exp_result),
    .err_count  (chk_errors),
    .done_count (done_seen)
  );

  //------------------------------------------------------------
  // Random source and reference model
  //------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic next_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function automatic logic [`DIV_XLEN-1:0] take_bits(input int n);
    logic [`DIV_XLEN-1:0] val;
    val = '0;
    for (int k = 0; k < n; k++)
      val = {val[`DIV_XLEN-2:0], next_bit()};
    return val;
  endfunction

  // Division rules of the ISA, special cases first
  function automatic logic [`DIV_XLEN-1:0] ref_result(input div_op_e f_op,
                                                      input logic [`DIV_XLEN-1:0] a,
                                                      input logic [`DIV_XLEN-1:0] b);
    logic                        is_rem;
    logic                        is_signed;
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    is_rem    = (f_op == REM) || (f_op == REMU);
    is_signed = (f_op == DIV) || (f_op == REM);
    sa        = a;
    sb        = b;
    if (b == '0)
      return is_rem ? a : ALL_ONES;
    if (is_signed && (a == MOST_NEG) && (b == ALL_ONES))
      return is_rem ? '0 : a;
    case (f_op)
      DIV:     return sa / sb;
      REM:     return sa % sb;
      DIVU:    return a / b;
      default: return a % b;
    endcase
  endfunction

  task automatic add_row(input div_op_e r_op, input logic [`DIV_XLEN-1:0] r_a,
                         input logic [`DIV_XLEN-1:0] r_b,
                         input logic [`DIV_XLEN-1:0] r_exp);
    tbl_op[n_rows]  = r_op;
    tbl_a[n_rows]   = r_a;
    tbl_b[n_rows]   = r_b;
    tbl_exp[n_rows] = r_exp;
    n_rows++;
  endtask

  task automatic fill_directed_rows();
    // Unsigned, small and large, short dividend, equal, divide by one
    add_row(DIVU, 64'd100, 64'd7, 64'd14);
    add_row(REMU, 64'd100, 64'd7, 64'd2);
    add_row(DIVU, ALL_ONES, 64'd3, 64'h5555_5555_5555_5555);
    add_row(REMU, ALL_ONES, 64'd3, 64'd0);
    add_row(DIVU, 64'd5, 64'd9, 64'd0);
    add_row(REMU, 64'd5, 64'd9, 64'd5);
    add_row(DIVU, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 64'd1);
    add_row(REMU, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 64'd0);
    add_row(DIVU, 64'hdead_beef_0000_0001, 64'd1, 64'hdead_beef_0000_0001);
    add_row(DIVU, ALL_ONES, MOST_NEG, 64'd1);
    add_row(REMU, ALL_ONES, MOST_NEG, 64'h7fff_ffff_ffff_ffff);
    add_row(DIVU, 64'hfedc_ba98_7654_3210, 64'h10, 64'h0fed_cba9_8765_4321);
    // Signed, all four sign pairs
    add_row(DIV, 64'd7, 64'd2, 64'd3);
    add_row(REM, 64'd7, 64'd2, 64'd1);
    add_row(DIV, NEG7, 64'd2, NEG3);
    add_row(REM, NEG7, 64'd2, ALL_ONES);
    add_row(DIV, 64'd7, NEG2, NEG3);
    add_row(REM, 64'd7, NEG2, 64'd1);
    add_row(DIV, NEG7, NEG2, 64'd3);
    add_row(REM, NEG7, NEG2, ALL_ONES);
    // Zero divisor
    add_row(DIV, 64'h1234, 64'd0, ALL_ONES);
    add_row(DIVU, 64'd42, 64'd0, ALL_ONES);
    add_row(REM, NEG7, 64'd0, NEG7);
    add_row(REMU, 64'habcd, 64'd0, 64'habcd);
    // Signed overflow
    add_row(DIV, MOST_NEG, ALL_ONES, MOST_NEG);
    add_row(REM, MOST_NEG, ALL_ONES, 64'd0);
    add_row(DIVU, MOST_NEG, ALL_ONES, 64'd0);
  endtask

  task automatic fill_random_rows();
    div_op_e              r_op;
    logic [`DIV_XLEN-1:0] r_a;
    logic [`DIV_XLEN-1:0] r_b;
    logic [`DIV_XLEN-1:0] r_bits;
    for (int r = 0; r < N_RANDOM; r++)
    begin
      r_bits = take_bits(2);
      r_op   = div_op_e'(r_bits[1:0]);
      r_a    = take_bits(64);
      // Random right shift spreads the divisor width
      r_bits = take_bits(6);
      r_b    = take_bits(64) >> r_bits[5:0];
      r_bits = take_bits(1);
      if (((r_op == DIV) || (r_op == REM)) && r_bits[0])
        r_b = -r_b;
      add_row(r_op, r_a, r_b, ref_result(r_op, r_a, r_b));
    end
  endtask

  //------------------------------------------------------------
  // Clock and run limit
  //------------------------------------------------------------
  initial
  begin
    div_clk = 1'b0;
    forever #10 div_clk = ~div_clk;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge div_clk);
      cycle_cnt++;
    end
    $display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    $display("STATUS: FAIL");
    $finish;
  end

  //------------------------------------------------------------
  // Driving loop
  //------------------------------------------------------------
  initial
  begin
    int wait_cnt;
    cpurst_b   = 1'b0;
    start      = 1'b0;
    op         = DIV;
    src0       = '0;
    src1       = '0;
    exp_result = '0;
    tb_errors  = 0;
    n_rows     = 0;
    lfsr_state = 32'h9444b80b;
    fill_directed_rows();
    fill_random_rows();

    repeat (4) @(posedge div_clk);
    @(negedge div_clk);
    cpurst_b = 1'b1;

    for (int i = 0; i < n_rows; i++)
    begin
      @(negedge div_clk);
      start      = 1'b1;
      op         = tbl_op[i];
      src0       = tbl_a[i];
      src1       = tbl_b[i];
      exp_result = tbl_exp[i];
      @(negedge div_clk);
      start = 1'b0;
      // Every third row also pulses start mid-division
      if (i % 3 == 1)
      begin
        @(negedge div_clk);
        start = 1'b1;
        op    = REMU;
        src0  = ~tbl_a[i];
        src1  = 64'd3;
        @(negedge div_clk);
        start = 1'b0;
      end
      wait_cnt = 0;
      while (!done && (wait_cnt < DONE_WAIT))
      begin
        @(negedge div_clk);
        wait_cnt++;
      end
      // One idle cycle before the next row
      @(negedge div_clk);
    end

    repeat (5) @(negedge div_clk);
    // Ignored starts must not add done pulses
    if (done_seen != n_rows)
    begin
      tb_errors++;
      $display("Saw %0d done pulses for %0d accepted starts", done_seen, n_rows);
    end

    $display("Errors: %0d (checker %0d, testbench %0d) over %0d divisions",
             chk_errors + tb_errors, chk_errors, tb_errors, n_rows);
    if ((chk_errors + tb_errors) == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_div_check.sv
`timescale 1ns/1ps
`include "div_cfg.svh"
`default_nettype none

module tb_div_check (
  input  logic                 div_clk,
  input  logic                 cpurst_b,
  input  logic                 start,
  input  logic                 busy,
  input  logic                 done,
  input  logic [`DIV_XLEN-1:0] result,
  input  logic [`DIV_XLEN-1:0] exp_result,
  output int                   err_count,
  output int                   done_count
);

  // Longest legal wait from accepted start to done
  localparam int DONE_LIMIT = 40;

  logic [`DIV_XLEN-1:0] exp_q[$];
  logic [`DIV_XLEN-1:0] exp_val;
  logic                 active;
  int                   wait_cycles;

  //------------------------------------------------------------
  // Protocol and result monitor
  //------------------------------------------------------------
  // Sampled on the rising edge, inputs change on the falling edge
  always @(posedge div_clk)
  begin
    if (!cpurst_b)
    begin
      exp_q.delete();
      active      = 1'b0;
      wait_cycles = 0;
      err_count   = 0;
      done_count  = 0;
    end
    else
    begin
      if (done)
      begin
        done_count++;
        // Busy already low while done is high
        if (busy !== 1'b0)
        begin
          err_count++;
          $display("[ERROR] %0t ns: busy expected 0 got %b at done", $time, busy);
        end
        if (exp_q.size() == 0)
        begin
          err_count++;
          $display("Done pulse at %0t ns arrived with no division pending", $time);
        end
        else
        begin
          exp_val = exp_q.pop_front();
          if (result !== exp_val)
          begin
            err_count++;
            $display("[ERROR] %0t ns: result expected %h got %h", $time, exp_val, result);
          end
        end
        active = 1'b0;
      end
      else if (active)
      begin
        wait_cycles++;
        // Busy holds from the cycle after start up to done
        if (busy !== 1'b1)
        begin
          err_count++;
          $display("[ERROR] %0t ns: busy expected 1 got %b", $time, busy);
        end
        if (wait_cycles > DONE_LIMIT)
        begin
          err_count++;
          $display("Division started before %0t ns got no done within %0d cycles",
                   $time, DONE_LIMIT);
          void'(exp_q.pop_front());
          active = 1'b0;
        end
      end
      else if (busy !== 1'b0)
      begin
        err_count++;
        $display("[ERROR] %0t ns: busy expected 0 got %b while idle", $time, busy);
      end

      // Only a start seen while idle opens a division
      if (start && !busy)
      begin
        exp_q.push_back(exp_result);
        active      = 1'b1;
        wait_cycles = 0;
      end
    end
  end

endmodule

`default_nettype wire
